//--- Makefile
# Verilator flow for the MPU slot status block: lint, simulate, clean

VERILATOR  ?= verilator
FLIST      ?= mpu_sta_top.f
RTL_TOP    ?= mpu_sta_top
TB_TOP     ?= mpu_sta_tb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

# RTL part of the file list, in its compile order
RTL_SRCS := $(shell grep '^rtl/' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mpu_sta_top.f
rtl/mpu_sta_pkg.sv
rtl/mpu_slot_sta.sv
rtl/sta_frame_mon.sv
rtl/mpu_sta_rd.sv
rtl/mpu_sta_top.sv
sim/mpu_sta_asserts.sv
sim/mpu_sta_tb.sv

//--- rtl/mpu_slot_sta.sv
// Per-slot status parser, one instance per line slot, keeps words 1 and 2 of frames for its slot
`timescale 1ns/1ps

module mpu_slot_sta
    import mpu_sta_pkg::*;
#(
    parameter logic [slot_w-1:0] slot_num = '0
) (
    input  logic                  clk_150m,
    input  logic                  rst_150m,
    input  logic                  rd_hold,
    input  logic                  mpu_sta_dval,
    input  logic [sta_word_w-1:0] mpu_sta_data,
    output logic [sta_data_w-1:0] mpu_slot_sta1,
    output logic [sta_data_w-1:0] mpu_slot_sta2
);

    // Word position 0..frm_len, holds at frm_len for long bursts
    typedef logic [$clog2(frm_len + 1)-1:0] pos_t;

    logic [slot_w-1:0] slot_number;
    pos_t              word_pos;
    logic              hdr_vld;
    logic              own_slot;

    // Burst started with a header naming this slot
    assign own_slot = hdr_vld && (slot_number == slot_num);

    // ----------------------------------------------------------------------
    // Header capture and word position
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            slot_number <= '0;
            word_pos    <= '0;
            hdr_vld     <= 1'b0;
        end else if (!mpu_sta_dval) begin
            // Idle cycle ends the burst
            word_pos <= '0;
            hdr_vld  <= 1'b0;
        end else begin
            if (word_pos != pos_t'(frm_len)) begin
                word_pos <= word_pos + 1'b1;
            end
            // First word of the burst decides if it is tracked at all
            if (word_pos == '0) begin
                hdr_vld <= mpu_sta_data[sta_hdr_bit];
                if (mpu_sta_data[sta_hdr_bit]) begin
                    slot_number <= mpu_sta_data[slot_w-1:0];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Status word update, blocked while the host reads
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            mpu_slot_sta1 <= '0;
            mpu_slot_sta2 <= '0;
        end else if (mpu_sta_dval && own_slot && !rd_hold) begin
            // Word 1
            if (word_pos == pos_t'(1)) begin
                mpu_slot_sta1 <= mpu_sta_data[sta_data_w-1:0];
            end
            // Word 2
            if (word_pos == pos_t'(2)) begin
                mpu_slot_sta2 <= mpu_sta_data[sta_data_w-1:0];
            end
        end
    end

endmodule

//--- rtl/mpu_sta_pkg.sv
// Common widths, slot count and read FSM states for the MPU status logic, imported by every RTL block
package mpu_sta_pkg;

    // ----------------------------------------------------------------------
    // Status bus format
    // ----------------------------------------------------------------------

    // Full word on the MPU status bus
    localparam int sta_word_w = 18;

    // One slot status word, low part of a bus word
    localparam int sta_data_w = 16;

    // Set only in word 0 of a frame
    localparam int sta_hdr_bit = 17;

    // Slot number field in the header, bits 3..0
    localparam int slot_w = 4;

    // ----------------------------------------------------------------------
    // Slots and frames
    // ----------------------------------------------------------------------

    // Line slots present, numbers 8..15 are unused
    localparam int slot_cnt = 8;

    // Header plus two status words
    localparam int frm_len = 3;

    // Good and error frame counters
    localparam int cnt_w = 16;

    // ----------------------------------------------------------------------
    // Host read FSM
    // ----------------------------------------------------------------------

    // Idle, then one state per returned word
    typedef enum logic [1:0] {
        rd_idle,
        rd_word1,
        rd_word2
    } rd_state_e;

endpackage

//--- rtl/mpu_sta_rd.sv
// Host read FSM, returns both status words of one slot and holds slot updates during the read
`timescale 1ns/1ps

module mpu_sta_rd
    import mpu_sta_pkg::*;
(
    input  logic                                 clk_150m,
    input  logic                                 rst_150m,
    input  logic                                 rd_req,
    input  logic [slot_w-1:0]                    rd_slot,
    input  logic [slot_cnt-1:0][sta_data_w-1:0]  slot_sta1,
    input  logic [slot_cnt-1:0][sta_data_w-1:0]  slot_sta2,
    output logic                                 rd_dval,
    output logic [sta_data_w-1:0]                rd_data
);

    rd_state_e                     rd_state;
    logic [slot_w-1:0]             slot_q;
    logic [$clog2(slot_cnt)-1:0]   slot_idx;
    logic                          slot_vld;

    // Slot numbers past the last slot read back as zeros
    assign slot_vld = slot_q < slot_w'(slot_cnt);
    assign slot_idx = slot_q[$clog2(slot_cnt)-1:0];

    // ----------------------------------------------------------------------
    // Read FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            rd_state <= rd_idle;
            slot_q   <= '0;
            rd_dval  <= 1'b0;
            rd_data  <= '0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    rd_dval <= 1'b0;
                    rd_data <= '0;
                    // Request in the last data cycle is dropped
                    if (rd_req && !rd_dval) begin
                        slot_q   <= rd_slot;
                        rd_state <= rd_word1;
                    end
                end
                rd_word1: begin
                    // First data cycle, hold starts with it
                    rd_dval  <= 1'b1;
                    rd_data  <= slot_vld ? slot_sta1[slot_idx] : '0;
                    rd_state <= rd_word2;
                end
                rd_word2: begin
                    rd_dval  <= 1'b1;
                    rd_data  <= slot_vld ? slot_sta2[slot_idx] : '0;
                    rd_state <= rd_idle;
                end
                default: begin
                    rd_dval  <= 1'b0;
                    rd_state <= rd_idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/mpu_sta_top.sv
// Top level of the MPU slot status block, ties the slot parsers, frame monitor and host read FSM
`timescale 1ns/1ps

module mpu_sta_top
    import mpu_sta_pkg::*;
(
    input  logic                  clk_150m,
    input  logic                  rst_150m,
    input  logic                  mpu_sta_dval,
    input  logic [sta_word_w-1:0] mpu_sta_data,
    input  logic                  rd_req,
    input  logic [slot_w-1:0]     rd_slot,
    output logic                  rd_dval,
    output logic [sta_data_w-1:0] rd_data,
    output logic [cnt_w-1:0]      frm_ok_cnt,
    output logic [cnt_w-1:0]      frm_err_cnt
);

    // Status words of all slots, indexed by slot number
    logic [slot_cnt-1:0][sta_data_w-1:0] slot_sta1;
    logic [slot_cnt-1:0][sta_data_w-1:0] slot_sta2;

    // ----------------------------------------------------------------------
    // Slot parsers, rd_dval doubles as update hold
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < slot_cnt; i++) begin : g_slot
        mpu_slot_sta #(
            .slot_num (slot_w'(i))
        ) slot_i (
            .clk_150m      (clk_150m),
            .rst_150m      (rst_150m),
            .rd_hold       (rd_dval),
            .mpu_sta_dval  (mpu_sta_dval),
            .mpu_sta_data  (mpu_sta_data),
            .mpu_slot_sta1 (slot_sta1[i]),
            .mpu_slot_sta2 (slot_sta2[i])
        );
    end

    // Frame statistics on the same bus
    sta_frame_mon mon_i (
        .clk_150m     (clk_150m),
        .rst_150m     (rst_150m),
        .mpu_sta_dval (mpu_sta_dval),
        .mpu_sta_data (mpu_sta_data),
        .frm_ok_cnt   (frm_ok_cnt),
        .frm_err_cnt  (frm_err_cnt)
    );

    // Host side
    mpu_sta_rd rd_i (
        .clk_150m  (clk_150m),
        .rst_150m  (rst_150m),
        .rd_req    (rd_req),
        .rd_slot   (rd_slot),
        .slot_sta1 (slot_sta1),
        .slot_sta2 (slot_sta2),
        .rd_dval   (rd_dval),
        .rd_data   (rd_data)
    );

endmodule

//--- rtl/sta_frame_mon.sv
// Frame checker on the MPU status bus, counts good and malformed bursts with saturating counters
`timescale 1ns/1ps

module sta_frame_mon
    import mpu_sta_pkg::*;
(
    input  logic                  clk_150m,
    input  logic                  rst_150m,
    input  logic                  mpu_sta_dval,
    input  logic [sta_word_w-1:0] mpu_sta_data,
    output logic [cnt_w-1:0]      frm_ok_cnt,
    output logic [cnt_w-1:0]      frm_err_cnt
);

    // Burst length 0..frm_len+1, the top value marks an overlong burst
    typedef logic [$clog2(frm_len + 2)-1:0] len_t;

    len_t burst_len;
    logic hdr_ok;
    logic slot_ok;
    logic burst_end;
    logic frm_good;

    // First idle cycle after a burst
    assign burst_end = !mpu_sta_dval && (burst_len != '0);

    // Exact length, header flag and a slot that exists
    assign frm_good = (burst_len == len_t'(frm_len)) && hdr_ok && slot_ok;

    // ----------------------------------------------------------------------
    // Burst tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            burst_len <= '0;
            hdr_ok    <= 1'b0;
            slot_ok   <= 1'b0;
        end else if (mpu_sta_dval) begin
            if (burst_len != len_t'(frm_len + 1)) begin
                burst_len <= burst_len + 1'b1;
            end
            // Word 0 carries the header checks
            if (burst_len == '0) begin
                hdr_ok  <= mpu_sta_data[sta_hdr_bit];
                slot_ok <= mpu_sta_data[slot_w-1:0] < slot_w'(slot_cnt);
            end
        end else begin
            burst_len <= '0;
            hdr_ok    <= 1'b0;
            slot_ok   <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Frame counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            frm_ok_cnt  <= '0;
            frm_err_cnt <= '0;
        end else if (burst_end) begin
            // Both stick at all ones
            if (frm_good) begin
                if (frm_ok_cnt != '1) begin
                    frm_ok_cnt <= frm_ok_cnt + 1'b1;
                end
            end else if (frm_err_cnt != '1) begin
                frm_err_cnt <= frm_err_cnt + 1'b1;
            end
        end
    end

endmodule

//--- sim/mpu_sta_asserts.sv
// Concurrent checks bound into the read FSM and the frame monitor of the MPU status block
`timescale 1ns/1ps

module mpu_sta_asserts
    import mpu_sta_pkg::*;
(
    input logic             clk_150m,
    input logic             rst_150m,
    input logic             rd_req,
    input logic             rd_dval,
    input rd_state_e        rd_state,
    input logic [cnt_w-1:0] frm_ok_cnt,
    input logic [cnt_w-1:0] frm_err_cnt
);

    // ----------------------------------------------------------------------
    // Read data window
    // ----------------------------------------------------------------------
    // Data window opens two edges after each accepted request and never otherwise
    assert property (@(posedge clk_150m) disable iff (!rst_150m)
        (rd_dval && !$past(rd_dval)) == $past(rd_req && !rd_dval && rd_state == rd_idle, 2))
        else $error("rd_dval start does not match an accepted request");

    // Never three cycles in a row
    assert property (@(posedge clk_150m) disable iff (!rst_150m)
        rd_dval && $past(rd_dval) |-> !$past(rd_dval, 2))
        else $error("rd_dval longer than two cycles");

    // Never a single cycle
    assert property (@(posedge clk_150m) disable iff (!rst_150m)
        !rd_dval && $past(rd_dval) |-> $past(rd_dval, 2))
        else $error("rd_dval shorter than two cycles");

    // Low in reset and on the first edge out of it
    assert property (@(posedge clk_150m)
        (!rst_150m || $past(!rst_150m)) |-> !rd_dval)
        else $error("rd_dval high out of reset");

    // ----------------------------------------------------------------------
    // Frame counters only go up
    // ----------------------------------------------------------------------
    assert property (@(posedge clk_150m) disable iff (!rst_150m)
        frm_ok_cnt >= $past(frm_ok_cnt))
        else $error("frm_ok_cnt decreased");

    assert property (@(posedge clk_150m) disable iff (!rst_150m)
        frm_err_cnt >= $past(frm_err_cnt))
        else $error("frm_err_cnt decreased");

endmodule

// Read FSM instance, counters tied off
bind mpu_sta_rd mpu_sta_asserts rd_chk_i (
    .clk_150m    (clk_150m),
    .rst_150m    (rst_150m),
    .rd_req      (rd_req),
    .rd_dval     (rd_dval),
    .rd_state    (rd_state),
    .frm_ok_cnt  ('0),
    .frm_err_cnt ('0)
);

// Frame monitor instance, read side tied off
bind sta_frame_mon mpu_sta_asserts mon_chk_i (
    .clk_150m    (clk_150m),
    .rst_150m    (rst_150m),
    .rd_req      (1'b0),
    .rd_dval     (1'b0),
    .rd_state    (mpu_sta_pkg::rd_idle),
    .frm_ok_cnt  (frm_ok_cnt),
    .frm_err_cnt (frm_err_cnt)
);

//--- sim/mpu_sta_tb.sv
// Directed testbench for mpu_sta_top, drives MPU status frames and host reads against a reference model
`timescale 1ns/1ps

module mpu_sta_tb;
    import mpu_sta_pkg::*;

    // Read wait limit in clock cycles
    localparam int rd_timeout = 20;

    logic                  clk_150m = 1'b0;
    logic                  rst_150m;
    logic                  mpu_sta_dval;
    logic [sta_word_w-1:0] mpu_sta_data;
    logic                  rd_req;
    logic [slot_w-1:0]     rd_slot;
    logic                  rd_dval;
    logic [sta_data_w-1:0] rd_data;
    logic [cnt_w-1:0]      frm_ok_cnt;
    logic [cnt_w-1:0]      frm_err_cnt;

    // Reference model state
    logic [sta_data_w-1:0] exp_sta1 [slot_cnt];
    logic [sta_data_w-1:0] exp_sta2 [slot_cnt];
    logic [cnt_w-1:0]      exp_ok;
    logic [cnt_w-1:0]      exp_err;

    // Words of the next burst, header first
    logic [sta_word_w-1:0] burst_q [$];
    int                    err_cnt;
    int                    tmo_cnt;

    mpu_sta_top dut_i (
        .clk_150m     (clk_150m),
        .rst_150m     (rst_150m),
        .mpu_sta_dval (mpu_sta_dval),
        .mpu_sta_data (mpu_sta_data),
        .rd_req       (rd_req),
        .rd_slot      (rd_slot),
        .rd_dval      (rd_dval),
        .rd_data      (rd_data),
        .frm_ok_cnt   (frm_ok_cnt),
        .frm_err_cnt  (frm_err_cnt)
    );

    // 20 ns period
    always #10 clk_150m = ~clk_150m;

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_sta(input logic [sta_data_w-1:0] got, input logic [sta_data_w-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cnt(input logic [cnt_w-1:0] got, input logic [cnt_w-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Frame building and driving
    // ----------------------------------------------------------------------
    function automatic logic [sta_word_w-1:0] data_word(input logic [sta_data_w-1:0] v);
        return {{(sta_word_w - sta_data_w){1'b0}}, v};
    endfunction

    task automatic build_frame(input logic [slot_w-1:0] slot, input logic [sta_data_w-1:0] v1,
                               input logic [sta_data_w-1:0] v2);
        logic [sta_word_w-1:0] hdr;
        hdr = '0;
        hdr[sta_hdr_bit] = 1'b1;
        hdr[slot_w-1:0] = slot;
        burst_q = {};
        burst_q.push_back(hdr);
        burst_q.push_back(data_word(v1));
        burst_q.push_back(data_word(v2));
    endtask

    // One word per cycle, then idle until the counters have moved
    task automatic send_frame();
        foreach (burst_q[i]) begin
            @(negedge clk_150m);
            mpu_sta_dval = 1'b1;
            mpu_sta_data = burst_q[i];
        end
        @(negedge clk_150m);
        mpu_sta_dval = 1'b0;
        mpu_sta_data = '0;
        @(negedge clk_150m);
    endtask

    // Expected effect of the burst in burst_q, word 1 dropped under a read hold
    task automatic model_burst(input bit hold_w1);
        logic hdr;
        int   s;
        int   n;
        n = burst_q.size();
        hdr = burst_q[0][sta_hdr_bit];
        s = int'(burst_q[0][slot_w-1:0]);
        // Update rule works on word position alone
        if (hdr && s < slot_cnt) begin
            if (n >= 2 && !hold_w1) begin
                exp_sta1[s] = burst_q[1][sta_data_w-1:0];
            end
            if (n >= 3) begin
                exp_sta2[s] = burst_q[2][sta_data_w-1:0];
            end
        end
        if (n == frm_len && hdr && s < slot_cnt) begin
            if (exp_ok != '1) begin
                exp_ok++;
            end
        end else if (exp_err != '1) begin
            exp_err++;
        end
    endtask

    task automatic run_burst();
        send_frame();
        model_burst(1'b0);
        check_cnt(frm_ok_cnt, exp_ok, "frm_ok_cnt");
        check_cnt(frm_err_cnt, exp_err, "frm_err_cnt");
    endtask

    // ----------------------------------------------------------------------
    // Host reads
    // ----------------------------------------------------------------------
    // dup_req keeps rd_req high through the data cycles
    task automatic read_slot(input logic [slot_w-1:0] slot, input bit dup_req,
                             output logic [sta_data_w-1:0] w1, output logic [sta_data_w-1:0] w2);
        int waited;
        w1 = '0;
        w2 = '0;
        @(negedge clk_150m);
        rd_req = 1'b1;
        rd_slot = slot;
        @(negedge clk_150m);
        rd_req = 1'b0;
        waited = 0;
        while (!rd_dval && waited < rd_timeout) begin
            @(negedge clk_150m);
            waited++;
        end
        if (!rd_dval) begin
            $display("Timed out waiting for read data from slot %0d", slot);
            tmo_cnt++;
        end else begin
            w1 = rd_data;
            rd_req = dup_req;
            @(negedge clk_150m);
            check_flag(rd_dval, 1'b1, "rd_dval in second data cycle");
            w2 = rd_data;
            @(negedge clk_150m);
            rd_req = 1'b0;
            check_flag(rd_dval, 1'b0, "rd_dval after two data cycles");
            if (dup_req) begin
                @(negedge clk_150m);
                check_flag(rd_dval, 1'b0, "rd_dval after ignored request");
            end
        end
    endtask

    task automatic check_slot(input logic [slot_w-1:0] slot, input bit dup_req);
        logic [sta_data_w-1:0] w1, w2, e1, e2;
        read_slot(slot, dup_req, w1, w2);
        e1 = '0;
        e2 = '0;
        // Missing slots read back as zeros
        if (int'(slot) < slot_cnt) begin
            e1 = exp_sta1[int'(slot)];
            e2 = exp_sta2[int'(slot)];
        end
        check_sta(w1, e1, $sformatf("slot %0d word 1", slot));
        check_sta(w2, e2, $sformatf("slot %0d word 2", slot));
    endtask

    task automatic check_all();
        for (int s = 0; s < slot_cnt; s++) begin
            check_slot(slot_w'(s), 1'b0);
        end
        check_cnt(frm_ok_cnt, exp_ok, "frm_ok_cnt");
        check_cnt(frm_err_cnt, exp_err, "frm_err_cnt");
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_good_frames();
        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < slot_cnt; s++) begin
                build_frame(slot_w'(s), 16'($urandom()), 16'($urandom()));
                run_burst();
                // Neighbour slot keeps its words
                check_slot(slot_w'((s + 1) % slot_cnt), 1'b0);
            end
            check_all();
        end
    endtask

    task automatic test_bad_bursts();
        // No header flag
        build_frame(slot_w'(3), 16'($urandom()), 16'($urandom()));
        burst_q[0][sta_hdr_bit] = 1'b0;
        run_burst();
        // Slot past the last line slot
        build_frame(slot_w'(9), 16'($urandom()), 16'($urandom()));
        run_burst();
        // Four words, parser still takes words 1 and 2
        build_frame(slot_w'(5), 16'($urandom()), 16'($urandom()));
        burst_q.push_back(data_word(16'($urandom())));
        run_burst();
        // Two words, only sta1 moves
        build_frame(slot_w'(6), 16'($urandom()), 16'($urandom()));
        void'(burst_q.pop_back());
        run_burst();
        check_all();
    endtask

    task automatic test_read_hold();
        logic [sta_data_w-1:0] w1, w2;
        build_frame(slot_w'(2), 16'($urandom()), 16'($urandom()));
        fork
            read_slot(slot_w'(2), 1'b0, w1, w2);
            begin
                // Header in first data cycle, word 1 in second, word 2 after
                repeat (2) @(negedge clk_150m);
                send_frame();
            end
        join
        check_sta(w1, exp_sta1[2], "held read word 1");
        check_sta(w2, exp_sta2[2], "held read word 2");
        model_burst(1'b1);
        check_all();
    endtask

    task automatic test_read_edges();
        check_slot(slot_w'(12), 1'b0);
        check_slot(slot_w'(4), 1'b1);
        check_all();
    endtask

    // ----------------------------------------------------------------------
    // Run
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'hc91c));
        rst_150m = 1'b0;
        mpu_sta_dval = 1'b0;
        mpu_sta_data = '0;
        rd_req = 1'b0;
        rd_slot = '0;
        err_cnt = 0;
        tmo_cnt = 0;
        exp_ok = '0;
        exp_err = '0;
        for (int s = 0; s < slot_cnt; s++) begin
            exp_sta1[s] = '0;
            exp_sta2[s] = '0;
        end
        repeat (10) @(negedge clk_150m);
        rst_150m = 1'b1;
        check_all();
        test_good_frames();
        test_bad_bursts();
        test_read_hold();
        test_read_edges();
        $display("Checks done: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
